//--- Makefile
# Verilator build and run of the key sideload testbench

TOP := kv_key_sideload_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- sources.f
+incdir+verilog
verilog/kv_sideload_pkg.sv
verilog/kv_ctrl_regs.sv
verilog/kv_read_client.sv
verilog/kv_key_buffer.sv
verilog/key_sideload_drive.sv
verilog/kv_key_sideload_top.sv
test/tb_clock_gen.sv
test/kv_vault_model.sv
test/kv_key_sideload_tb.sv

//--- test/kv_key_sideload_tb.sv
//======================================
// Key sideload testbench top
// Register stimulus, request monitor,
// expected key model and assertions
//======================================

`timescale 1ns/10ps
`default_nettype none

`include "kv_sideload_params.svh"

module kv_key_sideload_tb;

  localparam int BUS_TIMEOUT  = 8;
  localparam int READ_TIMEOUT = 200;
  localparam int GOOD_READS   = 4;

  logic                           clk;
  logic                           reset_n;
  logic                           req;
  logic                           write;
  logic [`REG_ADDR_W-1:0]         addr;
  logic [31:0]                    wdata;
  logic [31:0]                    rdata;
  logic                           rd_valid;
  kv_sideload_pkg::kv_read_t      kv_read;
  kv_sideload_pkg::kv_rd_resp_t   kv_resp;
  kv_sideload_pkg::key_sideload_t key_out;
  logic                           busy;
  logic                           notif_intr;

  // Error counts, one per process
  int unsigned                    err_count;
  int unsigned                    mon_err;
  int unsigned                    prop_err;
  int unsigned                    tests_ok;
  int unsigned                    tests_bad;
  int unsigned                    req_count;
  logic                           busy_prev;
  logic [`KV_ENTRY_W-1:0]         exp_entry;

  tb_clock_gen u_clock_gen (
    .clk     (clk),
    .reset_n (reset_n)
  );

  kv_vault_model u_vault (
    .clk       (clk),
    .reset_n   (reset_n),
    .kv_read_i (kv_read),
    .kv_resp_o (kv_resp)
  );

  kv_key_sideload_top u_kv_key_sideload_top (
    .clk          (clk),
    .reset_n      (reset_n),
    .req_i        (req),
    .write_i      (write),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .rdata_o      (rdata),
    .rd_valid_o   (rd_valid),
    .kv_read_o    (kv_read),
    .kv_resp_i    (kv_resp),
    .key_o        (key_out),
    .busy_o       (busy),
    .notif_intr_o (notif_intr)
  );

  //======================================
  // Expected values
  //======================================

  // Vault word {entry, offset, A5, offset ^ entry}
  function automatic logic [31:0] expected_word(input logic [`KV_ENTRY_W-1:0] e,
                                                input logic [`KV_OFFSET_W-1:0] o);
    logic [7:0] e8;
    logic [7:0] o8;
    e8 = 8'(e);
    o8 = 8'(o);
    expected_word = {e8, o8, 8'hA5, o8 ^ e8};
  endfunction

  // Dword o at bits 32*o, bytes of each dword reversed
  function automatic logic [`KV_KEY_W-1:0] expected_key(input logic [`KV_ENTRY_W-1:0] e);
    logic [31:0]          w;
    logic [`KV_KEY_W-1:0] k;
    k = '0;
    for (int o = 0; o < `KV_KEY_DWORDS; o++) begin
      w = expected_word(e, o[`KV_OFFSET_W-1:0]);
      k[32*o +: 32] = {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
    expected_key = k;
  endfunction

  function automatic int unsigned total_errors();
    total_errors = err_count + mon_err + prop_err;
  endfunction

  //======================================
  // Checks
  //======================================

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    check_word(name, {31'b0, expected}, {31'b0, actual});
  endtask

  task automatic check_key(input logic [`KV_KEY_W-1:0] expected,
                           input logic [`KV_KEY_W-1:0] actual);
    assert (actual === expected) else begin
      $display("error at %0t: key_o.key expected %0h, got %0h", $time, expected, actual);
      err_count++;
    end
  endtask

  // Accepted requests walk offsets 0..7 of the chosen entry
  always @(negedge clk) begin
    if (busy && !busy_prev) begin
      req_count = 0;
    end
    busy_prev = busy;
    if (reset_n && kv_read.req && kv_resp.valid) begin
      assert (kv_read.entry == exp_entry && 32'(kv_read.offset) == req_count) else begin
        $display("error at %0t: kv_read_o entry/offset expected %0h/%0h, got %0h/%0h",
                 $time, exp_entry, req_count, kv_read.entry, kv_read.offset);
        mon_err++;
      end
      req_count++;
    end
  end

  // Request held with steady address until the vault answers
  assert property (@(posedge clk) disable iff (!reset_n)
    kv_read.req && !kv_resp.valid |=>
      kv_read.req && $stable(kv_read.entry) && $stable(kv_read.offset))
  else begin
    $display("error at %0t: kv_read_o dropped or moved before the vault answered", $time);
    prop_err++;
  end

  // No valid key while a read runs
  assert property (@(posedge clk) disable iff (!reset_n) key_out.valid |-> !busy)
  else begin
    $display("error at %0t: key_o.valid high while busy_o is high", $time);
    prop_err++;
  end

  // Interrupt rises only as a read finishes
  assert property (@(posedge clk) disable iff (!reset_n)
    $rose(notif_intr) |-> !busy && $past(busy))
  else begin
    $display("error at %0t: notif_intr_o rose outside the end of a read", $time);
    prop_err++;
  end

  //======================================
  // Bus and wait tasks
  //======================================

  task automatic reg_write(input logic [`REG_ADDR_W-1:0] a, input logic [31:0] d);
    @(posedge clk);
    req   <= 1'b1;
    write <= 1'b1;
    addr  <= a;
    wdata <= d;
    @(posedge clk);
    req   <= 1'b0;
    write <= 1'b0;
  endtask

  task automatic reg_read(input logic [`REG_ADDR_W-1:0] a, output logic [31:0] d);
    int n;
    @(posedge clk);
    req   <= 1'b1;
    write <= 1'b0;
    addr  <= a;
    @(posedge clk);
    req <= 1'b0;
    n = 0;
    d = '0;
    do begin
      @(negedge clk);
      n++;
    end while (!rd_valid && n < BUS_TIMEOUT);
    if (rd_valid) begin
      d = rdata;
    end else begin
      $display("timeout at %0t: no rd_valid_o for register %0d", $time, a);
      err_count++;
    end
  endtask

  task automatic wait_busy(input logic level, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (busy !== level && n < limit);
    if (busy !== level) begin
      $display("timeout at %0t: busy_o did not reach %0b in %0d cycles", $time, level, limit);
      err_count++;
    end
  endtask

  task automatic check_status(input logic ready, input logic valid,
                              input kv_sideload_pkg::kv_error_e err);
    logic [31:0] rd;
    reg_read(`REG_STATUS_ADDR, rd);
    check_word("STATUS", {16'h0000, err, 6'b0, valid, ready}, rd);
  endtask

  // Start a read and wait for the client to go idle again
  task automatic run_read(input logic [`KV_ENTRY_W-1:0] e);
    exp_entry = e;
    reg_write(`REG_CTRL_ADDR, {19'b0, e, 8'h01});
    wait_busy(1'b1, BUS_TIMEOUT);
    wait_busy(1'b0, READ_TIMEOUT);
  endtask

  task automatic check_good_key(input logic [`KV_ENTRY_W-1:0] e);
    check_bit("key_o.valid", 1'b1, key_out.valid);
    check_key(expected_key(e), key_out.key);
    check_word("request count", 32'(`KV_KEY_DWORDS), req_count);
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    if (total_errors() == errs_before) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: failed", name);
      tests_bad++;
    end
  endtask

  //======================================
  // Stimulus
  //======================================
  initial begin
    logic [31:0]            rd;
    logic [`KV_ENTRY_W-1:0] e;
    logic [`KV_ENTRY_W-1:0] e2;
    int unsigned            errs;
    int                     n;
    void'($urandom(32'h58d0_1e05));
    req       = 1'b0;
    write     = 1'b0;
    addr      = '0;
    wdata     = '0;
    exp_entry = '0;
    err_count = 0;
    tests_ok  = 0;
    tests_bad = 0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!reset_n && n < 20);
    if (!reset_n) begin
      $display("timeout at %0t: reset never released", $time);
      err_count++;
    end

    // Reset values
    errs = total_errors();
    check_bit("kv_read_o.req", 1'b0, kv_read.req);
    check_bit("key_o.valid", 1'b0, key_out.valid);
    check_bit("busy_o", 1'b0, busy);
    check_bit("notif_intr_o", 1'b0, notif_intr);
    check_status(1'b1, 1'b0, kv_sideload_pkg::KV_SUCCESS);
    finish_test("reset", errs);

    // Random good entries 0..30
    errs = total_errors();
    for (int i = 0; i < GOOD_READS; i++) begin
      e = 5'($urandom % 31);
      run_read(e);
      check_good_key(e);
      check_status(1'b1, 1'b1, kv_sideload_pkg::KV_SUCCESS);
    end
    finish_test("good reads", errs);

    // Sticky interrupt, clear, then set again by the next read
    errs = total_errors();
    check_bit("notif_intr_o", 1'b1, notif_intr);
    reg_write(`REG_INTR_ADDR, 32'h1);
    repeat (4) begin
      @(negedge clk);
      check_bit("notif_intr_o", 1'b0, notif_intr);
    end
    e = 5'($urandom % 31);
    run_read(e);
    check_bit("notif_intr_o", 1'b1, notif_intr);
    finish_test("interrupt", errs);

    // Locked entry stops after one request
    errs = total_errors();
    reg_write(`REG_INTR_ADDR, 32'h1);
    run_read(5'd31);
    check_word("request count", 32'd1, req_count);
    check_bit("key_o.valid", 1'b0, key_out.valid);
    check_key('0, key_out.key);
    check_bit("notif_intr_o", 1'b1, notif_intr);
    check_status(1'b1, 1'b0, kv_sideload_pkg::KV_READ_FAIL);
    e = 5'($urandom % 31);
    run_read(e);
    check_good_key(e);
    check_status(1'b1, 1'b1, kv_sideload_pkg::KV_SUCCESS);
    finish_test("locked entry", errs);

    // Restart drops the key, start while busy is ignored
    errs = total_errors();
    e  = 5'($urandom % 31);
    e2 = e ^ 5'h0a;
    exp_entry = e;
    reg_write(`REG_CTRL_ADDR, {19'b0, e, 8'h01});
    @(negedge clk);
    check_bit("key_o.valid", 1'b1, key_out.valid);
    @(negedge clk);
    check_bit("key_o.valid", 1'b0, key_out.valid);
    check_bit("kv_read_o.req", 1'b1, kv_read.req);
    check_bit("busy_o", 1'b1, busy);
    // Second start once dwords already sit in the buffer
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (req_count < 2 && n < READ_TIMEOUT);
    if (req_count < 2) begin
      $display("timeout at %0t: vault answered fewer than 2 requests", $time);
      err_count++;
    end
    reg_write(`REG_CTRL_ADDR, {19'b0, e2, 8'h01});
    wait_busy(1'b0, READ_TIMEOUT);
    check_good_key(e);
    repeat (4) begin
      @(negedge clk);
      check_bit("busy_o", 1'b0, busy);
    end
    check_word("request count", 32'(`KV_KEY_DWORDS), req_count);
    reg_read(`REG_CTRL_ADDR, rd);
    check_word("CTRL[12:8]", {27'b0, e2}, {27'b0, rd[12:8]});
    finish_test("restart and busy", errs);

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_ok, tests_bad, total_errors());
    if (total_errors() == 0 && tests_bad == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/kv_vault_model.sv
//======================================
// Behavioral key vault
// Random 0..3 cycle delay, entry 31 locked
//======================================

`timescale 1ns/10ps
`default_nettype none

`include "kv_sideload_params.svh"

module kv_vault_model (
  input  wire                                clk,
  input  wire                                reset_n,
  input  wire  kv_sideload_pkg::kv_read_t    kv_read_i,
  output kv_sideload_pkg::kv_rd_resp_t       kv_resp_o
);

  localparam logic [`KV_ENTRY_W-1:0] LOCKED_ENTRY = 5'd31;

  // Stored word {entry, offset, A5, offset ^ entry}
  function automatic logic [31:0] vault_word(input logic [`KV_ENTRY_W-1:0] e,
                                             input logic [`KV_OFFSET_W-1:0] o);
    vault_word = {8'(e), 8'(o), 8'hA5, 8'(o) ^ 8'(e)};
  endfunction

  initial begin
    logic [`KV_ENTRY_W-1:0]  entry;
    logic [`KV_OFFSET_W-1:0] offset;
    int unsigned             delay;
    kv_resp_o = '0;
    forever begin
      // Look at the request between edges
      @(negedge clk);
      if (reset_n && kv_read_i.req) begin
        entry  = kv_read_i.entry;
        offset = kv_read_i.offset;
        delay  = $urandom % 4;
        repeat (delay) @(negedge clk);
        @(posedge clk);
        kv_resp_o.valid <= 1'b1;
        if (entry == LOCKED_ENTRY) begin
          kv_resp_o.data  <= 32'h0;
          kv_resp_o.error <= 1'b1;
        end else begin
          kv_resp_o.data  <= vault_word(entry, offset);
          kv_resp_o.error <= 1'b0;
        end
        // One-cycle response
        @(posedge clk);
        kv_resp_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
//======================================
// Testbench clock and reset
// 100 ns clock, reset low for 5 cycles
//======================================

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset_n
);

  localparam int RESET_CYCLES = 5;

  // Half period of 50 ns
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Release on a rising edge
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/key_sideload_drive.sv
//======================================
// Sideload key driver
// Key plus valid toward the cipher engine
//======================================

`timescale 1ns/10ps
`default_nettype none

`include "kv_sideload_params.svh"

module key_sideload_drive (
  input  wire                                  clk,
  input  wire                                  reset_n,
  input  wire  kv_sideload_pkg::kv_read_ctrl_t read_ctrl_i,
  input  wire  kv_sideload_pkg::kv_error_e     error_code_i,
  input  wire                                  read_done_i,
  input  wire  [`KV_KEY_W-1:0]                 key_i,
  output kv_sideload_pkg::key_sideload_t       sideload_o
);

  kv_sideload_pkg::key_sideload_t sideload_q;
  logic                           invalidate;

  // New request or failed fetch kills the key
  assign invalidate = read_ctrl_i.read_en ||
                      (error_code_i == kv_sideload_pkg::KV_READ_FAIL);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sideload_q <= '0;
    end else if (invalidate) begin
      sideload_q <= '0;
    end else if (read_done_i) begin
      // Buffer is complete here
      sideload_q.valid <= 1'b1;
      sideload_q.key   <= key_i;
    end
  end

  assign sideload_o = sideload_q;

endmodule

`default_nettype wire

//--- verilog/kv_ctrl_regs.sv
//======================================
// Control, status and interrupt registers
// Plain strobe bus, one-cycle read latency
//======================================

`timescale 1ns/10ps
`default_nettype none

`include "kv_sideload_params.svh"

module kv_ctrl_regs (
  input  wire                             clk,
  input  wire                             reset_n,
  // Host strobe bus
  input  wire                             req_i,
  input  wire                             write_i,
  input  wire  [`REG_ADDR_W-1:0]          addr_i,
  input  wire  [31:0]                     wdata_i,
  output logic [31:0]                     rdata_o,
  output logic                            rd_valid_o,
  // Status from the datapath
  input  wire                             kv_ready_i,
  input  wire                             key_valid_i,
  input  wire  kv_sideload_pkg::kv_error_e error_code_i,
  input  wire                             read_done_i,
  // Control out
  output kv_sideload_pkg::kv_read_ctrl_t  read_ctrl_o,
  output logic                            notif_intr_o
);

  localparam int unsigned CTRL_PAD_W = 32 - 8 - `KV_ENTRY_W;

  logic [`KV_ENTRY_W-1:0]         ctrl_entry_q;
  kv_sideload_pkg::kv_read_ctrl_t read_ctrl_q;
  logic                           intr_q;
  logic                           rd_valid_q;
  logic [31:0]                    rdata_q;
  logic [31:0]                    rdata_d;
  logic                           wr_ctrl;
  logic                           wr_intr;
  logic                           rd_req;
  logic                           start_ok;

  // Address decode
  assign wr_ctrl = req_i && write_i && (addr_i == `REG_CTRL_ADDR);
  assign wr_intr = req_i && write_i && (addr_i == `REG_INTR_ADDR);
  assign rd_req  = req_i && !write_i;

  // No start while busy or while a pulse is already out
  assign start_ok = kv_ready_i && !read_ctrl_q.read_en;

  //======================================
  // Control and interrupt state
  //======================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ctrl_entry_q <= '0;
      read_ctrl_q  <= '0;
      intr_q       <= 1'b0;
      rd_valid_q   <= 1'b0;
    end else begin
      rd_valid_q          <= rd_req;
      read_ctrl_q.read_en <= wr_ctrl && wdata_i[0] && start_ok;
      // Entry field always stored, even when busy
      if (wr_ctrl) begin
        ctrl_entry_q <= wdata_i[8 +: `KV_ENTRY_W];
      end
      if (wr_ctrl && wdata_i[0] && start_ok) begin
        read_ctrl_q.entry <= wdata_i[8 +: `KV_ENTRY_W];
      end
      // Sticky done flag, set beats clear
      if (read_done_i) begin
        intr_q <= 1'b1;
      end else if (wr_intr && wdata_i[0]) begin
        intr_q <= 1'b0;
      end
    end
  end

  // Read mux
  always_comb begin
    case (addr_i)
      `REG_CTRL_ADDR:   rdata_d = {{CTRL_PAD_W{1'b0}}, ctrl_entry_q, 8'h00};
      `REG_STATUS_ADDR: rdata_d = {16'h0000, error_code_i, 6'b0, key_valid_i, kv_ready_i};
      `REG_INTR_ADDR:   rdata_d = {31'b0, intr_q};
      default:          rdata_d = '0;
    endcase
  end

  // Read data, only meaningful with rd_valid
  always_ff @(posedge clk) begin
    if (rd_req) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o      = rdata_q;
  assign rd_valid_o   = rd_valid_q;
  assign read_ctrl_o  = read_ctrl_q;
  assign notif_intr_o = intr_q;

endmodule

`default_nettype wire

//--- verilog/kv_key_buffer.sv
//======================================
// Key buffer, eight dwords
// Byte swap on write, clear on new read
//======================================

`timescale 1ns/10ps
`default_nettype none

`include "kv_sideload_params.svh"

module kv_key_buffer (
  input  wire                      clk,
  input  wire                      reset_n,
  input  wire                      clear_i,
  input  wire                      wr_en_i,
  input  wire  [`KV_OFFSET_W-1:0]  wr_offset_i,
  input  wire  [31:0]              wr_data_i,
  output logic [`KV_KEY_W-1:0]     key_o
);

  logic [`KV_KEY_DWORDS-1:0][3:0][7:0] key_q;
  logic [3:0][7:0]                     swz_data;

  // Engine wants the opposite byte order
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      swz_data[b] = wr_data_i[8*(3-b) +: 8];
    end
  end

  // Dword store
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_q <= '0;
    end else if (clear_i) begin
      // Wipe stale key bits on every new request
      key_q <= '0;
    end else if (wr_en_i) begin
      key_q[wr_offset_i] <= swz_data;
    end
  end

  assign key_o = key_q;

endmodule

`default_nettype wire

//--- verilog/kv_key_sideload_top.sv
//======================================
// Key vault sideload top
// Registers, read client, buffer, driver
//======================================

`timescale 1ns/10ps
`default_nettype none

`include "kv_sideload_params.svh"

module kv_key_sideload_top (
  input  wire                                clk,
  input  wire                                reset_n,
  // Register bus
  input  wire                                req_i,
  input  wire                                write_i,
  input  wire  [`REG_ADDR_W-1:0]             addr_i,
  input  wire  [31:0]                        wdata_i,
  output logic [31:0]                        rdata_o,
  output logic                               rd_valid_o,
  // Key vault
  output kv_sideload_pkg::kv_read_t          kv_read_o,
  input  wire  kv_sideload_pkg::kv_rd_resp_t kv_resp_i,
  // Engine side
  output kv_sideload_pkg::key_sideload_t     key_o,
  output logic                               busy_o,
  output logic                               notif_intr_o
);

  kv_sideload_pkg::kv_read_ctrl_t read_ctrl;
  kv_sideload_pkg::kv_error_e     error_code;
  logic                           kv_ready;
  logic                           read_done;
  logic                           key_wr_en;
  logic [`KV_OFFSET_W-1:0]        key_wr_offset;
  logic [31:0]                    key_wr_data;
  logic [`KV_KEY_W-1:0]           key_buf;

  assign busy_o = ~kv_ready;

  kv_ctrl_regs u_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .req_i        (req_i),
    .write_i      (write_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .rdata_o      (rdata_o),
    .rd_valid_o   (rd_valid_o),
    .kv_ready_i   (kv_ready),
    .key_valid_i  (key_o.valid),
    .error_code_i (error_code),
    .read_done_i  (read_done),
    .read_ctrl_o  (read_ctrl),
    .notif_intr_o (notif_intr_o)
  );

  kv_read_client u_client (
    .clk             (clk),
    .reset_n         (reset_n),
    .read_ctrl_i     (read_ctrl),
    .kv_read_o       (kv_read_o),
    .kv_resp_i       (kv_resp_i),
    .key_wr_en_o     (key_wr_en),
    .key_wr_offset_o (key_wr_offset),
    .key_wr_data_o   (key_wr_data),
    .error_code_o    (error_code),
    .kv_ready_o      (kv_ready),
    .read_done_o     (read_done)
  );

  // Start pulse doubles as buffer clear
  kv_key_buffer u_buffer (
    .clk         (clk),
    .reset_n     (reset_n),
    .clear_i     (read_ctrl.read_en),
    .wr_en_i     (key_wr_en),
    .wr_offset_i (key_wr_offset),
    .wr_data_i   (key_wr_data),
    .key_o       (key_buf)
  );

  key_sideload_drive u_sideload (
    .clk          (clk),
    .reset_n      (reset_n),
    .read_ctrl_i  (read_ctrl),
    .error_code_i (error_code),
    .read_done_i  (read_done),
    .key_i        (key_buf),
    .sideload_o   (key_o)
  );

endmodule

`default_nettype wire

//--- verilog/kv_read_client.sv
//======================================
// Key vault read client FSM
// Fetches one entry, dword by dword
//======================================

`timescale 1ns/10ps
`default_nettype none

`include "kv_sideload_params.svh"

module kv_read_client (
  input  wire                             clk,
  input  wire                             reset_n,
  input  wire  kv_sideload_pkg::kv_read_ctrl_t read_ctrl_i,
  // Vault side
  output kv_sideload_pkg::kv_read_t       kv_read_o,
  input  wire  kv_sideload_pkg::kv_rd_resp_t   kv_resp_i,
  // Key buffer side
  output logic                            key_wr_en_o,
  output logic [`KV_OFFSET_W-1:0]         key_wr_offset_o,
  output logic [31:0]                     key_wr_data_o,
  // Status
  output kv_sideload_pkg::kv_error_e      error_code_o,
  output logic                            kv_ready_o,
  output logic                            read_done_o
);

  kv_sideload_pkg::kv_client_state_e state_q;
  kv_sideload_pkg::kv_error_e        error_q;
  logic [`KV_ENTRY_W-1:0]            entry_q;
  logic [`KV_OFFSET_W-1:0]           offset_q;
  logic                              resp_accept;
  logic                              last_dword;

  // Request held through REQ and WAIT_RESP
  always_comb begin
    kv_read_o.req    = (state_q == kv_sideload_pkg::REQ) ||
                       (state_q == kv_sideload_pkg::WAIT_RESP);
    kv_read_o.entry  = entry_q;
    kv_read_o.offset = offset_q;
  end

  // Responses with req low are dropped
  assign resp_accept = kv_read_o.req && kv_resp_i.valid;
  assign last_dword  = (32'(offset_q) == (`KV_KEY_DWORDS - 1));

  //======================================
  // FSM
  //======================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q  <= kv_sideload_pkg::IDLE;
      error_q  <= kv_sideload_pkg::KV_SUCCESS;
      entry_q  <= '0;
      offset_q <= '0;
    end else begin
      case (state_q)
        kv_sideload_pkg::IDLE: begin
          // Latch entry, restart from dword 0
          if (read_ctrl_i.read_en) begin
            entry_q  <= read_ctrl_i.entry;
            offset_q <= '0;
            error_q  <= kv_sideload_pkg::KV_SUCCESS;
            state_q  <= kv_sideload_pkg::REQ;
          end
        end
        kv_sideload_pkg::REQ, kv_sideload_pkg::WAIT_RESP: begin
          if (resp_accept) begin
            if (kv_resp_i.error) begin
              // Stop on first failure
              error_q <= kv_sideload_pkg::KV_READ_FAIL;
              state_q <= kv_sideload_pkg::DONE;
            end else if (last_dword) begin
              state_q <= kv_sideload_pkg::DONE;
            end else begin
              offset_q <= offset_q + 1'b1;
              state_q  <= kv_sideload_pkg::REQ;
            end
          end else begin
            state_q <= kv_sideload_pkg::WAIT_RESP;
          end
        end
        kv_sideload_pkg::DONE: state_q <= kv_sideload_pkg::IDLE;
        default:               state_q <= kv_sideload_pkg::IDLE;
      endcase
    end
  end

  // Good words go straight to the buffer
  assign key_wr_en_o     = resp_accept && !kv_resp_i.error;
  assign key_wr_offset_o = offset_q;
  assign key_wr_data_o   = kv_resp_i.data;

  // Status levels and done pulse
  assign error_code_o = error_q;
  assign kv_ready_o   = (state_q == kv_sideload_pkg::IDLE);
  assign read_done_o  = (state_q == kv_sideload_pkg::DONE);

endmodule

`default_nettype wire

//--- verilog/kv_sideload_params.svh
//======================================
// Key vault sideload sizes and widths
// Register word addresses
//======================================

`ifndef KV_SIDELOAD_PARAMS_SVH
`define KV_SIDELOAD_PARAMS_SVH

// Key geometry, 8 dwords of 32 bits
`define KV_KEY_DWORDS 8
`define KV_KEY_W      (`KV_KEY_DWORDS * 32)

// Vault entry index and dword offset
`define KV_ENTRY_W    5
`define KV_OFFSET_W   3

// Register bus word addresses
`define REG_ADDR_W      4
`define REG_CTRL_ADDR   4'd0
`define REG_STATUS_ADDR 4'd1
`define REG_INTR_ADDR   4'd2

`endif

//--- verilog/kv_sideload_pkg.sv
//======================================
// Shared types for the key sideload path
// Vault bus structs, error and FSM enums
// Control pulse and sideload key structs
//======================================

`default_nettype none

`include "kv_sideload_params.svh"

package kv_sideload_pkg;

  //======================================
  // Vault interface
  //======================================

  // Request toward the vault, held until valid
  typedef struct packed {
    logic                    req;
    logic [`KV_ENTRY_W-1:0]  entry;
    logic [`KV_OFFSET_W-1:0] offset;
  } kv_read_t;

  // One-cycle response from the vault
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        error;
  } kv_rd_resp_t;

  //======================================
  // Enums
  //======================================

  // Error code as seen in STATUS[15:8]
  typedef enum logic [7:0] {
    KV_SUCCESS   = 8'h00,
    KV_READ_FAIL = 8'h01
  } kv_error_e;

  // Read client FSM
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    REQ       = 2'd1,
    WAIT_RESP = 2'd2,
    DONE      = 2'd3
  } kv_client_state_e;

  //======================================
  // Internal control and key output
  //======================================

  // Start pulse plus latched entry
  typedef struct packed {
    logic                   read_en;
    logic [`KV_ENTRY_W-1:0] entry;
  } kv_read_ctrl_t;

  // Key handed to the cipher engine
  typedef struct packed {
    logic                 valid;
    logic [`KV_KEY_W-1:0] key;
  } key_sideload_t;

endpackage

`default_nettype wire
